/* masked_sbox.f */
rtl/gf_pkg.sv
rtl/share_pkg.sv
rtl/tower_share_if.sv
rtl/gf16_shared_mult.sv
rtl/sbox_entry_stage.sv
rtl/shared_gf16_inverter.sv
rtl/sbox_output_stage.sv
rtl/masked_sbox_top.sv
sim/tb_masked_sbox.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the masked sbox testbench with Verilator.
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert \
    --top-module tb_masked_sbox \
    -f masked_sbox.f \
    -o tb_masked_sbox \
    && ./obj_dir/tb_masked_sbox \
    || { echo "simulation run reported an error"; exit 1; }

/* sim/tb_masked_sbox.sv */
`timescale 1ns/10ps
`default_nettype none

module tb_masked_sbox;

    localparam int LATENCY     = 4;   // Steps from drive to a readable result.
    localparam int DRAIN_LIMIT = 16;

    logic                         clk;
    logic                         rst_n;
    logic [7:0]                   share_in [4];
    logic [share_pkg::RAND_W-1:0] rnd;
    wire  [7:0]                   out_0;
    wire  [7:0]                   out_1;
    wire  [7:0]                   out_2;

    logic [7:0]   exp_q [$];          // Expected unmasked result.
    logic [7:0]   in_q [$];           // Unmasked input, for messages.
    int           due_q [$];          // Step at which the result is readable.
    int           tag_q [$];
    int           cyc;
    logic [255:0] seen;
    int           track_count;
    logic [7:0]   first_s0;
    logic         s0_varied;

    masked_sbox_top u_dut (
        .i_clk     (clk),
        .i_rst_n   (rst_n),
        .i_share_0 (share_in[0]),
        .i_share_1 (share_in[1]),
        .i_share_2 (share_in[2]),
        .i_share_3 (share_in[3]),
        .i_random  (rnd),
        .o_share_0 (out_0),
        .o_share_1 (out_1),
        .o_share_2 (out_2)
    );

    always #5 clk = ~clk;

    // AES field, modulus x^8+x^4+x^3+x+1.
    function automatic logic [7:0] gf256_mul(input logic [7:0] a, input logic [7:0] b);
        logic [7:0] acc;
        logic [7:0] aa;
        acc = 8'h00;
        aa  = a;
        for (int i = 0; i < 8; i++) begin
            if (b[i]) begin
                acc = acc ^ aa;
            end
            aa = aa[7] ? ({aa[6:0], 1'b0} ^ 8'h1b) : {aa[6:0], 1'b0};
        end
        return acc;
    endfunction

    function automatic logic [7:0] gf256_inv(input logic [7:0] x);
        logic [7:0] r;
        logic [7:0] base;
        int         e;
        r    = 8'h01;
        base = x;
        e    = 254;  // x^254, which also sends 0 to 0.
        while (e > 0) begin
            if (e[0]) begin
                r = gf256_mul(r, base);
            end
            base = gf256_mul(base, base);
            e    = e >> 1;
        end
        return r;
    endfunction

    function automatic logic [7:0] affine_model(input logic [7:0] b);
        logic [7:0] c;
        logic [7:0] r;
        c = 8'h63;
        for (int i = 0; i < 8; i++) begin
            r[i] = b[i] ^ b[(i + 4) % 8] ^ b[(i + 5) % 8] ^ b[(i + 6) % 8]
                 ^ b[(i + 7) % 8] ^ c[i];
        end
        return r;
    endfunction

    function automatic logic [7:0] sbox_model(input logic [7:0] x);
        return affine_model(gf256_inv(x));
    endfunction

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("tests failed");
        $fatal(1, "run aborted");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("MISMATCH at %0d ns: %s: got %0h, expected %0h",
                     $time, what, actual, expected);
            abort_run("value check failed");
        end
    endtask

    // Fresh shares and fresh randomness every call.
    task automatic drive_shares(input logic [7:0] value);
        logic [7:0] m0;
        logic [7:0] m1;
        logic [7:0] m2;
        m0 = 8'($urandom());
        m1 = 8'($urandom());
        m2 = 8'($urandom());
        share_in[0] = m0;
        share_in[1] = m1;
        share_in[2] = m2;
        share_in[3] = value ^ m0 ^ m1 ^ m2;
        rnd         = {4'($urandom()), 32'($urandom())};
    endtask

    task automatic check_oldest();
        logic [7:0] exp_v;
        logic [7:0] in_v;
        int         tag;
        exp_v = exp_q.pop_front();
        in_v  = in_q.pop_front();
        tag   = tag_q.pop_front();
        void'(due_q.pop_front());
        check_value(32'(out_0 ^ out_1 ^ out_2), 32'(exp_v),
                    $sformatf("unmasked output for input %02h", in_v));
        seen[in_v] = 1'b1;
        if (tag == 1) begin
            track_count = track_count + 1;
            if (track_count == 1) begin
                first_s0 = out_0;
            end else if (out_0 != first_s0) begin
                s0_varied = 1'b1;
            end
        end
    endtask

    // One clock step: check what is due, then drive the next input.
    task automatic step(input logic [7:0] value, input logic [7:0] expected,
                        input logic send, input int tag);
        @(posedge clk);
        #1;
        cyc = cyc + 1;
        if (due_q.size() > 0 && due_q[0] == cyc) begin
            check_oldest();
        end
        if (send) begin
            drive_shares(value);
            exp_q.push_back(expected);
            in_q.push_back(value);
            due_q.push_back(cyc + LATENCY);
            tag_q.push_back(tag);
        end else begin
            drive_shares(8'($urandom()));
        end
    endtask

    task automatic send_random_stream(input int count);
        logic [7:0] v;
        for (int n = 0; n < count; n++) begin
            v = 8'($urandom());
            step(v, sbox_model(v), 1'b1, 0);
        end
    endtask

    task automatic drain_pipeline();
        int waited;
        waited = 0;
        while (due_q.size() > 0) begin
            if (waited >= DRAIN_LIMIT) begin
                abort_run("pending sbox results did not arrive within the drain limit");
            end
            step(8'h00, 8'h00, 1'b0, 0);
            waited = waited + 1;
        end
    endtask

    task automatic check_outputs_zero(input string what);
        check_value(32'(out_0), 32'h0, {what, ", share 0"});
        check_value(32'(out_1), 32'h0, {what, ", share 1"});
        check_value(32'(out_2), 32'h0, {what, ", share 2"});
    endtask

    task automatic apply_reset();
        rst_n = 1'b0;
        #1;
        check_outputs_zero("output at reset assertion");
        exp_q.delete();
        in_q.delete();
        due_q.delete();
        tag_q.delete();
        for (int n = 0; n < 3; n++) begin
            @(posedge clk);
            #1;
            cyc = cyc + 1;
            share_in[0] = 8'h00;
            share_in[1] = 8'h00;
            share_in[2] = 8'h00;
            share_in[3] = 8'h00;
            rnd         = '0;
            check_outputs_zero("output during reset");
        end
        rst_n = 1'b1;
        #1;
        check_outputs_zero("output in the first cycle after reset");
    endtask

    initial begin
        clk         = 1'b0;
        rst_n       = 1'b1;
        share_in[0] = 8'h00;
        share_in[1] = 8'h00;
        share_in[2] = 8'h00;
        share_in[3] = 8'h00;
        rnd         = '0;
        cyc         = 0;
        seen        = '0;
        track_count = 0;
        first_s0    = 8'h00;
        s0_varied   = 1'b0;
        void'($urandom(81604));
        #1;

        // Known AES values keep the model honest.
        check_value(32'(sbox_model(8'h00)), 32'h63, "model sbox(00)");
        check_value(32'(sbox_model(8'h01)), 32'h7c, "model sbox(01)");
        check_value(32'(sbox_model(8'h53)), 32'hed, "model sbox(53)");

        apply_reset();

        send_random_stream(200);
        drain_pipeline();

        for (int n = 0; n < 8; n++) begin
            step(8'h00, 8'h63, 1'b1, 0);  // Zero input gives the affine constant.
        end
        drain_pipeline();

        seen = '0;
        for (int v = 0; v < 256; v++) begin
            step(8'(v), sbox_model(8'(v)), 1'b1, 0);
        end
        drain_pipeline();
        check_value(32'($countones(seen)), 32'd256, "distinct input values checked");

        for (int n = 0; n < 50; n++) begin
            step(8'h3c, sbox_model(8'h3c), 1'b1, 1);
        end
        drain_pipeline();
        check_value(32'(track_count), 32'd50, "repeated trials checked");
        check_value(32'(s0_varied), 32'd1, "output share 0 changes across trials");

        send_random_stream(10);
        apply_reset();
        send_random_stream(100);
        drain_pipeline();

        $display("all tests passed");
        $finish;
    end

endmodule

`default_nettype wire

/* rtl/masked_sbox_top.sv */
`timescale 1ns/10ps
`default_nettype none

module masked_sbox_top (
    input  wire                             i_clk,
    input  wire                             i_rst_n,
    input  wire [7:0]                       i_share_0,
    input  wire [7:0]                       i_share_1,
    input  wire [7:0]                       i_share_2,
    input  wire [7:0]                       i_share_3,
    input  wire [share_pkg::RAND_W-1:0]     i_random,
    output wire [7:0]                       o_share_0,
    output wire [7:0]                       o_share_1,
    output wire [7:0]                       o_share_2
);

    logic [share_pkg::N_IN_SHARES-1:0][7:0]  in_share_w;
    logic [share_pkg::N_OUT_SHARES-1:0][7:0] out_share_w;
    share_pkg::out_shares_t                  inv_w;

    tower_share_if u_tower ();

    assign in_share_w = {i_share_3, i_share_2, i_share_1, i_share_0};

    sbox_entry_stage u_entry (
        .i_clk   (i_clk),
        .i_rst_n (i_rst_n),
        .i_share (in_share_w),
        .o_tower (u_tower.entry)
    );

    shared_gf16_inverter u_inverter (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_random (i_random),
        .i_tower  (u_tower.inv),
        .o_inv    (inv_w)
    );

    sbox_output_stage u_output (
        .i_clk    (i_clk),
        .i_rst_n  (i_rst_n),
        .i_random (i_random),
        .i_tower  (u_tower.tail),
        .i_inv    (inv_w),
        .o_share  (out_share_w)
    );

    assign o_share_0 = out_share_w[0];
    assign o_share_1 = out_share_w[1];
    assign o_share_2 = out_share_w[2];

endmodule

`default_nettype wire

/* rtl/sbox_output_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module sbox_output_stage (
    input  wire                                         i_clk,
    input  wire                                         i_rst_n,
    input  wire [share_pkg::RAND_W-1:0]                 i_random,
    tower_share_if.tail                                 i_tower,
    input  wire share_pkg::out_shares_t                 i_inv,
    output logic [share_pkg::N_OUT_SHARES-1:0][7:0]     o_share
);

    share_pkg::in_shares_t  hi_d1;
    share_pkg::in_shares_t  hi_d2;
    share_pkg::in_shares_t  sum_d1;
    share_pkg::in_shares_t  sum_d2;
    share_pkg::in_shares_t  inv_w;
    share_pkg::out_shares_t new_hi_w;
    share_pkg::out_shares_t new_lo_w;

    logic [share_pkg::N_OUT_SHARES-1:0][7:0] out_w;

    // Two stages to match the inverter latency.
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            hi_d1  <= '0;
            hi_d2  <= '0;
            sum_d1 <= '0;
            sum_d2 <= '0;
        end else begin
            hi_d1  <= i_tower.hi;
            hi_d2  <= hi_d1;
            sum_d1 <= i_tower.sum;
            sum_d2 <= sum_d1;
        end
    end

    assign inv_w = share_pkg::refresh(i_inv,
        i_random[share_pkg::RAND_OUT +: share_pkg::RAND_SLICE_W]);

    gf16_shared_mult u_mult_hi (
        .i_a (hi_d2),
        .i_b (inv_w),
        .o_p (new_hi_w)
    );

    gf16_shared_mult u_mult_lo (
        .i_a (sum_d2),
        .i_b (inv_w),
        .o_p (new_lo_w)
    );

    always_comb begin
        gf_pkg::gf256_u word;
        for (int j = 0; j < share_pkg::N_OUT_SHARES; j++) begin
            word.tower.hi = new_hi_w[j];
            word.tower.lo = new_lo_w[j];
            out_w[j]      = gf_pkg::affine_lin(gf_pkg::inv_iso_map(word.raw));
        end
        out_w[0] = out_w[0] ^ gf_pkg::AFFINE_CONST;  // Added once for the whole sharing.
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_share <= '0;
        end else begin
            o_share <= out_w;
        end
    end

    // Holds only while every earlier stage and the random input stay known.
    a_out_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_rst_n |=> !$isunknown(o_share));

endmodule

`default_nettype wire

/* rtl/shared_gf16_inverter.sv */
`timescale 1ns/10ps
`default_nettype none

module shared_gf16_inverter (
    input  wire                             i_clk,
    input  wire                             i_rst_n,
    input  wire [share_pkg::RAND_W-1:0]     i_random,
    tower_share_if.inv                      i_tower,
    output share_pkg::out_shares_t          o_inv
);

    share_pkg::in_shares_t  d_w;   // Refreshed delta.
    share_pkg::in_shares_t  d2_w;
    share_pkg::in_shares_t  d4_w;
    share_pkg::in_shares_t  d8_w;
    share_pkg::in_shares_t  d8_q;
    share_pkg::in_shares_t  p_w;   // Refreshed d^6.
    share_pkg::out_shares_t d6_w;
    share_pkg::out_shares_t d6_q;
    share_pkg::out_shares_t inv_w;

    assign d_w = share_pkg::refresh(i_tower.delta,
        i_random[share_pkg::RAND_INV_IN +: share_pkg::RAND_SLICE_W]);

    // Squaring is linear, so it runs share by share.
    always_comb begin
        for (int i = 0; i < share_pkg::N_IN_SHARES; i++) begin
            d2_w[i] = gf_pkg::gf16_sq(d_w[i]);
            d4_w[i] = gf_pkg::gf16_sq(d2_w[i]);
            d8_w[i] = gf_pkg::gf16_sq(d4_w[i]);
        end
    end

    gf16_shared_mult u_mult_d6 (
        .i_a (d2_w),
        .i_b (d4_w),
        .o_p (d6_w)
    );

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            d6_q <= '0;
            d8_q <= '0;
        end else begin
            d6_q <= d6_w;
            d8_q <= d8_w;
        end
    end

    assign p_w = share_pkg::refresh(d6_q,
        i_random[share_pkg::RAND_INV_MID +: share_pkg::RAND_SLICE_W]);

    // d^14 is the inverse in GF(2^4) and maps 0 to 0.
    gf16_shared_mult u_mult_d14 (
        .i_a (p_w),
        .i_b (d8_q),
        .o_p (inv_w)
    );

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_inv <= '0;
        end else begin
            o_inv <= inv_w;
        end
    end

endmodule

`default_nettype wire

/* rtl/sbox_entry_stage.sv */
`timescale 1ns/10ps
`default_nettype none

module sbox_entry_stage (
    input  wire                                     i_clk,
    input  wire                                     i_rst_n,
    input  wire [share_pkg::N_IN_SHARES-1:0][7:0]   i_share,
    tower_share_if.entry                            o_tower
);

    share_pkg::in_shares_t  hi_w;
    share_pkg::in_shares_t  lo_w;
    share_pkg::in_shares_t  sum_w;
    share_pkg::out_shares_t prod_w;
    share_pkg::out_shares_t delta_w;

    always_comb begin
        gf_pkg::gf256_u word;
        for (int i = 0; i < share_pkg::N_IN_SHARES; i++) begin
            word.raw = gf_pkg::iso_map(i_share[i]);
            hi_w[i]  = word.tower.hi;
            lo_w[i]  = word.tower.lo;
            sum_w[i] = word.tower.hi ^ word.tower.lo;
        end
    end

    gf16_shared_mult u_norm_mult (
        .i_a (sum_w),
        .i_b (lo_w),
        .o_p (prod_w)
    );

    // Square terms follow the index that each product share already leaves out.
    always_comb begin
        delta_w[0] = prod_w[0] ^ gf_pkg::sq_scale(hi_w[1]) ^ gf_pkg::sq_scale(hi_w[2]);
        delta_w[1] = prod_w[1] ^ gf_pkg::sq_scale(hi_w[3]);
        delta_w[2] = prod_w[2] ^ gf_pkg::sq_scale(hi_w[0]);
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_tower.delta <= '0;
            o_tower.hi    <= '0;
            o_tower.sum   <= '0;
        end else begin
            o_tower.delta <= delta_w;
            o_tower.hi    <= hi_w;
            o_tower.sum   <= sum_w;
        end
    end

    // Known input shares at the top give a known norm one cycle later.
    a_delta_known: assert property (@(posedge i_clk) disable iff (!i_rst_n)
        i_rst_n |=> !$isunknown(o_tower.delta));

endmodule

`default_nettype wire

/* rtl/gf16_shared_mult.sv */
`timescale 1ns/10ps
`default_nettype none

module gf16_shared_mult (
    input  wire share_pkg::in_shares_t  i_a,
    input  wire share_pkg::in_shares_t  i_b,
    output share_pkg::out_shares_t      o_p
);

    // Output share k never sees input index k, so no share holds the full secret.
    always_comb begin
        o_p[0] = gf_pkg::gf16_mul(i_a[1], i_b[1])
               ^ gf_pkg::gf16_mul(i_a[1], i_b[2])
               ^ gf_pkg::gf16_mul(i_a[2], i_b[1])
               ^ gf_pkg::gf16_mul(i_a[1], i_b[3])
               ^ gf_pkg::gf16_mul(i_a[3], i_b[1]);

        o_p[1] = gf_pkg::gf16_mul(i_a[2], i_b[2])
               ^ gf_pkg::gf16_mul(i_a[0], i_b[2])
               ^ gf_pkg::gf16_mul(i_a[2], i_b[0])
               ^ gf_pkg::gf16_mul(i_a[2], i_b[3])
               ^ gf_pkg::gf16_mul(i_a[3], i_b[2])
               ^ gf_pkg::gf16_mul(i_a[3], i_b[3]);

        o_p[2] = gf_pkg::gf16_mul(i_a[0], i_b[0])
               ^ gf_pkg::gf16_mul(i_a[0], i_b[1])
               ^ gf_pkg::gf16_mul(i_a[1], i_b[0])
               ^ gf_pkg::gf16_mul(i_a[0], i_b[3])
               ^ gf_pkg::gf16_mul(i_a[3], i_b[0]);
    end

endmodule

`default_nettype wire

/* rtl/tower_share_if.sv */
`timescale 1ns/10ps
`default_nettype none

interface tower_share_if ();

    share_pkg::out_shares_t delta;  // Norm of the tower element.
    share_pkg::in_shares_t  hi;
    share_pkg::in_shares_t  sum;    // hi ^ lo per share.

    modport entry (
        output delta,
        output hi,
        output sum
    );

    modport inv (
        input delta
    );

    modport tail (
        input hi,
        input sum
    );

endinterface

`default_nettype wire

/* rtl/share_pkg.sv */
`default_nettype none

package share_pkg;

    localparam int N_IN_SHARES  = 4;
    localparam int N_OUT_SHARES = 3;

    typedef gf_pkg::gf16_t [N_IN_SHARES-1:0]  in_shares_t;
    typedef gf_pkg::gf16_t [N_OUT_SHARES-1:0] out_shares_t;

    // Nine nibbles per cycle, three per refresh point.
    localparam int RAND_W       = 36;
    localparam int RAND_SLICE_W = $bits(out_shares_t);
    localparam int RAND_INV_IN  = 0;                 // Delta into the inverter.
    localparam int RAND_INV_MID = RAND_SLICE_W;      // Partial product d^6.
    localparam int RAND_OUT     = 2 * RAND_SLICE_W;  // Inverse into the output stage.

    // Three shares back up to four, the last share carries the mask sum.
    function automatic in_shares_t refresh(out_shares_t s, out_shares_t m);
        in_shares_t r;
        for (int i = 0; i < N_OUT_SHARES; i++) begin
            r[i] = s[i] ^ m[i];
        end
        r[N_OUT_SHARES] = m[0] ^ m[1] ^ m[2];
        return r;
    endfunction

endpackage

`default_nettype wire

/* rtl/gf_pkg.sv */
`default_nettype none

package gf_pkg;

    typedef logic [3:0] gf16_t;  // Polynomial basis, x^4+x+1.

    typedef struct packed {
        gf16_t hi;
        gf16_t lo;
    } tower_t;

    typedef union packed {
        logic [7:0] raw;
        tower_t     tower;
    } gf256_u;

    localparam gf16_t      LAMBDA       = 4'he;  // Trace 1, so y^2+y+LAMBDA is irreducible.
    localparam logic [7:0] AFFINE_CONST = 8'h63;

    function automatic gf16_t gf16_mul(gf16_t a, gf16_t b);
        gf16_t p;
        gf16_t s;
        p = '0;
        s = a;
        for (int i = 0; i < 4; i++) begin
            if (b[i]) begin
                p = p ^ s;
            end
            s = {s[2:0], 1'b0} ^ (s[3] ? 4'h3 : 4'h0);
        end
        return p;
    endfunction

    function automatic gf16_t gf16_sq(gf16_t a);
        return gf16_mul(a, a);
    endfunction

    function automatic gf16_t sq_scale(gf16_t a);
        return gf16_mul(gf16_sq(a), LAMBDA);
    endfunction

    // Tower product with y^2 = y + LAMBDA.
    function automatic logic [7:0] tower_mul(logic [7:0] a, logic [7:0] b);
        gf16_t hh;
        hh = gf16_mul(a[7:4], b[7:4]);
        return {hh ^ gf16_mul(a[7:4], b[3:0]) ^ gf16_mul(a[3:0], b[7:4]),
                gf16_mul(hh, LAMBDA) ^ gf16_mul(a[3:0], b[3:0])};
    endfunction

    // Column k holds the image of bit k.
    function automatic logic [7:0] mat_mul(logic [63:0] m, logic [7:0] x);
        logic [7:0] r;
        r = '0;
        for (int k = 0; k < 8; k++) begin
            if (x[k]) begin
                r = r ^ m[8*k +: 8];
            end
        end
        return r;
    endfunction

    // First tower root of x^8+x^4+x^3+x+1 gives the basis images beta^k.
    function automatic logic [63:0] derive_iso_map();
        logic [63:0]     cols;
        logic [8:0][7:0] pw;
        cols = '0;
        for (int c = 2; c < 256; c++) begin
            pw[0] = 8'h01;
            for (int k = 1; k < 9; k++) begin
                pw[k] = tower_mul(pw[k-1], 8'(c));
            end
            if ((pw[8] ^ pw[4] ^ pw[3] ^ pw[1] ^ pw[0]) == 8'h00 && cols == '0) begin
                cols = pw[7:0];
            end
        end
        return cols;
    endfunction

    function automatic logic [63:0] derive_inv_map(logic [63:0] fwd);
        logic [63:0] cols;
        logic [7:0]  img;
        cols = '0;
        for (int v = 0; v < 256; v++) begin
            img = mat_mul(fwd, 8'(v));
            for (int k = 0; k < 8; k++) begin
                if (img == (8'h01 << k)) begin
                    cols[8*k +: 8] = 8'(v);
                end
            end
        end
        return cols;
    endfunction

    localparam logic [63:0] ISO_MAP     = derive_iso_map();
    localparam logic [63:0] INV_ISO_MAP = derive_inv_map(ISO_MAP);

    function automatic logic [7:0] iso_map(logic [7:0] x);
        return mat_mul(ISO_MAP, x);
    endfunction

    function automatic logic [7:0] inv_iso_map(logic [7:0] x);
        return mat_mul(INV_ISO_MAP, x);
    endfunction

    // Linear part only, the constant is added to one share.
    function automatic logic [7:0] affine_lin(logic [7:0] x);
        return x ^ {x[6:0], x[7]} ^ {x[5:0], x[7:6]} ^ {x[4:0], x[7:5]} ^ {x[3:0], x[7:4]};
    endfunction

endpackage

`default_nettype wire
